// File: include/mm_sched_cfg.svh
// ------------------------------
// Array geometry and counter sizes of the scheduler
// Included by the package and by every RTL module
// ------------------------------
`ifndef MM_SCHED_CFG_SVH
`define MM_SCHED_CFG_SVH

// Engine rows and columns
`define MMS_ARRAY_H 4
`define MMS_ARRAY_W 4

// Pipeline registers inside each FMA
`define MMS_PIPE_REGS 2

// Tile depth is rows times pipe registers plus one
`define MMS_DEPTH ((`MMS_ARRAY_H * `MMS_PIPE_REGS) + `MMS_ARRAY_H)

// Width of every iteration counter
`define MMS_ITER_W 16

`endif

// File: hdl/mm_sched_pkg.sv
// ------------------------------
// Types shared by the scheduler blocks and the testbench
// ------------------------------
`include "mm_sched_cfg.svh"

package mm_sched_pkg;

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } sched_state_e;

  // Job configuration, stable while a job runs
  typedef struct packed {
    logic [`MMS_ITER_W-1:0] x_col_iters;
    logic [`MMS_ITER_W-1:0] x_row_iters;
    logic [`MMS_ITER_W-1:0] w_col_iters;
    logic [`MMS_ITER_W-1:0] w_row_iters;
    logic [7:0]             x_height_lo;
    logic [7:0]             x_width_lo;
    logic [7:0]             w_height_lo;
    logic [7:0]             w_width_lo;
    logic                   y_needed;
  } iter_cfg_t;

  // Status flags coming back from the X and Z buffers
  typedef struct packed {
    logic x_full;
    logic x_empty;
    logic z_empty;
    logic z_loaded;
  } buf_flags_t;

  typedef struct packed {
    logic       load;
    logic       h_shift;
    logic       rst_w_index;
    logic       pad_setup;
    logic       last_x;
    logic [7:0] height;
    logic [7:0] slots;
    logic [7:0] width;
  } x_ctrl_t;

  typedef struct packed {
    logic                   load;
    logic                   shift;
    logic [7:0]             height;
    logic [7:0]             width;
    logic [`MMS_ARRAY_H-1:0] zero_set;
  } w_ctrl_t;

  typedef struct packed {
    logic       y_valid;
    logic       ready;
    logic       y_push_enable;
    logic       fill;
    logic       first_load;
    logic [7:0] y_width;
    logic [7:0] y_height;
    logic [7:0] z_width;
    logic [7:0] z_height;
  } z_ctrl_t;

endpackage

// File: hdl/x_iter_ctrl.sv
// ------------------------------
// X tile iteration, reload and horizontal shift control
// ------------------------------
`include "mm_sched_cfg.svh"

module x_iter_ctrl
  import mm_sched_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  iter_cfg_t    cfg_i,
  input  buf_flags_t   flags_i,
  input  logic         x_valid_i,
  input  sched_state_e state_i,
  input  logic         stall_i,
  output x_ctrl_t      x_ctrl_o,
  output logic         x_refill_due_o,
  output logic         x_shift_end_o
);

  localparam int unsigned ShiftW = $clog2(`MMS_ARRAY_H);

  logic [`MMS_ITER_W-1:0] cols_q, witer_q, rows_q;
  logic                   cols_last, witer_last, rows_last;
  logic                   cols_en, witer_en, rows_en, done_en;
  logic                   x_done_q;
  logic [ShiftW-1:0]      shift_q;
  logic                   shift_en, shift_end;
  logic                   start, reload_q, reload_en, reload_rst;
  logic                   empty_full_q, refill_q;
  logic [7:0]             height_lo_up;

  assign cols_last  = cols_q == cfg_i.x_col_iters - 1'b1;
  assign witer_last = witer_q == cfg_i.w_col_iters - 1'b1;
  assign rows_last  = rows_q == cfg_i.x_row_iters - 1'b1;

  // The empty flag is a single-cycle pulse, so it steps the column count directly
  assign cols_en  = flags_i.x_empty && !x_done_q;
  assign witer_en = cols_en && cols_last;
  assign rows_en  = witer_en && witer_last;
  assign done_en  = rows_en && rows_last;

  assign start     = (state_i == IDLE) && start_i;
  assign shift_en  = (state_i == LOAD_W) && !stall_i;
  assign shift_end = shift_q == ShiftW'(`MMS_ARRAY_H - 1);

  // A reload is requested on start, after each consumed tile, or when the
  // buffer drained while it still reported full
  assign reload_en  = start || flags_i.x_empty || (empty_full_q && !flags_i.x_full);
  assign reload_rst = flags_i.x_full && !reload_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q       <= '0;
      witer_q      <= '0;
      rows_q       <= '0;
      x_done_q     <= 1'b0;
      shift_q      <= '0;
      reload_q     <= 1'b0;
      empty_full_q <= 1'b0;
      refill_q     <= 1'b0;
    end else if (clear_i) begin
      cols_q       <= '0;
      witer_q      <= '0;
      rows_q       <= '0;
      x_done_q     <= 1'b0;
      shift_q      <= '0;
      reload_q     <= 1'b0;
      empty_full_q <= 1'b0;
      refill_q     <= 1'b0;
    end else begin
      if (cols_en) begin
        cols_q <= cols_last ? '0 : cols_q + 1'b1;
      end
      if (witer_en) begin
        witer_q <= witer_last ? '0 : witer_q + 1'b1;
      end
      if (rows_en) begin
        rows_q <= rows_q + 1'b1;
      end
      if (done_en) begin
        x_done_q <= 1'b1;
      end
      if (shift_en) begin
        shift_q <= shift_end ? '0 : shift_q + 1'b1;
      end
      if (reload_rst) begin
        reload_q <= 1'b0;
      end else if (reload_en) begin
        reload_q <= 1'b1;
      end
      if (!flags_i.x_full) begin
        empty_full_q <= 1'b0;
      end else if (flags_i.x_empty) begin
        empty_full_q <= 1'b1;
      end
      if (x_ctrl_o.rst_w_index) begin
        refill_q <= 1'b0;
      end else if (flags_i.x_empty) begin
        refill_q <= 1'b1;
      end
    end
  end

  // Slots are counted in whole groups of ARRAY_H rows
  assign height_lo_up = (cfg_i.x_height_lo + 8'(`MMS_ARRAY_H - 1)) & ~8'(`MMS_ARRAY_H - 1);

  assign x_ctrl_o.load        = (reload_q || start) && !reload_rst && x_valid_i;
  assign x_ctrl_o.h_shift     = shift_en;
  assign x_ctrl_o.rst_w_index = shift_en && shift_end && flags_i.x_full;
  assign x_ctrl_o.pad_setup   = (state_i == PRELOAD) && flags_i.x_full &&
                                (!cfg_i.y_needed || flags_i.z_loaded);
  assign x_ctrl_o.last_x      = done_en;
  assign x_ctrl_o.height      = (cols_last && cfg_i.x_height_lo != '0) ?
                                cfg_i.x_height_lo : 8'(`MMS_DEPTH);
  assign x_ctrl_o.slots       = (cols_last && cfg_i.x_height_lo != '0) ?
                                height_lo_up : 8'(`MMS_DEPTH);
  assign x_ctrl_o.width       = (rows_last && cfg_i.x_width_lo != '0) ?
                                cfg_i.x_width_lo : 8'(`MMS_ARRAY_W);

  assign x_refill_due_o = refill_q && shift_end && !x_done_q;
  assign x_shift_end_o  = shift_end;

endmodule

// File: hdl/w_iter_ctrl.sv
// ------------------------------
// W row, column and matrix iteration with zero padding at the end
// ------------------------------
`include "mm_sched_cfg.svh"

module w_iter_ctrl
  import mm_sched_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  iter_cfg_t    cfg_i,
  input  logic         w_valid_i,
  input  sched_state_e state_i,
  input  logic         stall_i,
  output w_ctrl_t      w_ctrl_o,
  output logic         w_done_o,
  output logic         w_col_wrap_o
);

  localparam int unsigned ZeroW = $clog2(`MMS_ARRAY_H) + 1;

  logic [`MMS_ITER_W-1:0] rows_q, cols_q, mats_q;
  logic                   rows_last, cols_last, mats_last;
  logic                   rows_en, cols_en, mats_en;
  logic                   w_done_q;
  logic [ZeroW-1:0]       zero_q;
  logic [`MMS_ITER_W:0]   rows_ahead;

  assign rows_last = rows_q == cfg_i.w_row_iters - 1'b1;
  assign cols_last = cols_q == cfg_i.w_col_iters - 1'b1;
  assign mats_last = mats_q == cfg_i.x_row_iters - 1'b1;

  assign rows_en = (state_i == LOAD_W) && w_valid_i && !stall_i && !w_done_q;
  assign cols_en = rows_en && rows_last;
  assign mats_en = cols_en && cols_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q   <= '0;
      cols_q   <= '0;
      mats_q   <= '0;
      w_done_q <= 1'b0;
      zero_q   <= '0;
    end else if (clear_i) begin
      rows_q   <= '0;
      cols_q   <= '0;
      mats_q   <= '0;
      w_done_q <= 1'b0;
      zero_q   <= '0;
    end else begin
      if (rows_en) begin
        rows_q <= rows_last ? '0 : rows_q + 1'b1;
      end
      if (cols_en) begin
        cols_q <= cols_last ? '0 : cols_q + 1'b1;
      end
      if (mats_en) begin
        mats_q   <= mats_q + 1'b1;
        w_done_q <= mats_last;
      end
      // Once all weights are in, one more row is zeroed per LOAD_W cycle
      if (w_done_q && state_i == LOAD_W && zero_q != ZeroW'(`MMS_ARRAY_H)) begin
        zero_q <= zero_q + 1'b1;
      end
    end
  end

  // The leftover height applies to the last PIPE_REGS+1 rows of a column
  assign rows_ahead = {1'b0, rows_q} + (`MMS_ITER_W + 1)'(`MMS_PIPE_REGS + 1);

  assign w_ctrl_o.height = (rows_ahead >= {1'b0, cfg_i.w_row_iters} && cfg_i.w_height_lo != '0) ?
                           cfg_i.w_height_lo : 8'(`MMS_ARRAY_H);
  assign w_ctrl_o.width  = (cols_last && cfg_i.w_width_lo != '0) ?
                           cfg_i.w_width_lo : 8'(`MMS_DEPTH);
  assign w_ctrl_o.load   = (state_i == LOAD_W) && !stall_i && !w_done_q;
  assign w_ctrl_o.shift  = (state_i == LOAD_W || state_i == WAIT) && !stall_i;

  always_comb begin
    w_ctrl_o.zero_set = '0;
    for (int unsigned i = 0; i < `MMS_ARRAY_H; i++) begin
      w_ctrl_o.zero_set[i] = w_done_q && (zero_q > ZeroW'(i));
    end
  end

  assign w_done_o     = w_done_q;
  assign w_col_wrap_o = cols_en;

endmodule

// File: hdl/z_iter_ctrl.sv
// ------------------------------
// Y/Z tile iteration with the Z wait, Z availability and Y push counters
// ------------------------------
`include "mm_sched_cfg.svh"

module z_iter_ctrl
  import mm_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  iter_cfg_t  cfg_i,
  input  buf_flags_t flags_i,
  input  logic       y_valid_i,
  input  logic       z_ready_i,
  input  logic       stall_i,
  input  logic       start_compute_i,
  input  logic       reg_enable_i,
  input  logic       w_col_wrap_i,
  input  logic       w_done_i,
  output z_ctrl_t    z_ctrl_o,
  output logic       y_check_due_o,
  output logic       z_avail_clr_o,
  output logic       pushing_y_o
);

  localparam int unsigned WaitW = $clog2(`MMS_PIPE_REGS + 1);

  logic [`MMS_ITER_W-1:0] cols_q, rows_q;
  logic                   cols_last, rows_last;
  logic [WaitW-1:0]       wait_q;
  logic                   wait_en_q, wait_step, wait_clr;
  logic [7:0]             avail_q, push_q;
  logic                   avail_en_q, avail_clr;
  logic                   push_en_q, push_set, push_clr;
  logic                   pushing_q;
  logic [7:0]             y_width, y_height, z_width_q, z_height_q;

  assign cols_last = cols_q == cfg_i.w_col_iters - 1'b1;
  assign rows_last = rows_q == cfg_i.w_row_iters - 1'b1;

  assign wait_step = wait_en_q && !stall_i;
  assign wait_clr  = wait_step && wait_q == WaitW'(`MMS_PIPE_REGS);
  assign avail_clr = avail_en_q && !stall_i && avail_q == z_height_q - 1'b1;
  assign push_clr  = push_en_q && !stall_i && push_q == y_height - 1'b1;

  // The next Y tile starts entering one cycle before the current wait expires
  assign push_set  = (wait_step && wait_q == WaitW'(`MMS_PIPE_REGS - 1)) || start_compute_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q     <= '0;
      rows_q     <= '0;
      wait_en_q  <= 1'b0;
      wait_q     <= '0;
      avail_en_q <= 1'b0;
      avail_q    <= '0;
      push_en_q  <= 1'b0;
      push_q     <= '0;
      pushing_q  <= 1'b0;
      z_width_q  <= '0;
      z_height_q <= '0;
    end else if (clear_i) begin
      cols_q     <= '0;
      rows_q     <= '0;
      wait_en_q  <= 1'b0;
      wait_q     <= '0;
      avail_en_q <= 1'b0;
      avail_q    <= '0;
      push_en_q  <= 1'b0;
      push_q     <= '0;
      pushing_q  <= 1'b0;
      z_width_q  <= '0;
      z_height_q <= '0;
    end else begin
      if (flags_i.z_empty) begin
        cols_q <= cols_last ? '0 : cols_q + 1'b1;
        if (cols_last) begin
          rows_q <= rows_last ? '0 : rows_q + 1'b1;
        end
      end
      if (wait_clr) begin
        wait_en_q <= 1'b0;
      end else if (w_col_wrap_i) begin
        wait_en_q <= 1'b1;
      end
      if (wait_step) begin
        wait_q <= wait_clr ? '0 : wait_q + 1'b1;
      end
      if (avail_clr) begin
        avail_en_q <= 1'b0;
      end else if (wait_clr) begin
        avail_en_q <= 1'b1;
      end
      if (avail_en_q && !stall_i) begin
        avail_q <= avail_clr ? '0 : avail_q + 1'b1;
      end
      if (push_clr) begin
        push_en_q <= 1'b0;
      end else if (push_set) begin
        push_en_q <= 1'b1;
      end
      if (push_en_q && !stall_i) begin
        push_q <= push_clr ? '0 : push_q + 1'b1;
      end
      pushing_q <= push_en_q;
      if (flags_i.z_empty || start_compute_i) begin
        z_width_q  <= y_width;
        z_height_q <= y_height;
      end
    end
  end

  assign y_width  = (rows_last && cfg_i.w_height_lo != '0) ? cfg_i.w_height_lo : 8'(`MMS_ARRAY_W);
  assign y_height = (cols_last && cfg_i.w_width_lo != '0) ? cfg_i.w_width_lo : 8'(`MMS_DEPTH);

  assign z_ctrl_o.y_valid       = y_valid_i;
  assign z_ctrl_o.ready         = z_ready_i;
  assign z_ctrl_o.y_push_enable = push_en_q && !stall_i;
  assign z_ctrl_o.fill          = avail_en_q && reg_enable_i;
  assign z_ctrl_o.first_load    = cols_q == '0 && rows_q == '0;
  assign z_ctrl_o.y_width       = y_width;
  assign z_ctrl_o.y_height      = y_height;
  assign z_ctrl_o.z_width       = z_width_q;
  assign z_ctrl_o.z_height      = z_height_q;

  assign y_check_due_o = wait_q == WaitW'(`MMS_PIPE_REGS) && !w_done_i;
  assign z_avail_clr_o = avail_clr;
  assign pushing_y_o   = pushing_q;

endmodule

// File: hdl/sched_fsm.sv
// ------------------------------
// Scheduler FSM with the stall checks and the engine enables
// ------------------------------
`include "mm_sched_cfg.svh"

module sched_fsm
  import mm_sched_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  iter_cfg_t    cfg_i,
  input  buf_flags_t   flags_i,
  input  logic         w_valid_i,
  input  logic         x_refill_due_i,
  input  logic         x_shift_end_i,
  input  logic         w_done_i,
  input  logic         y_check_due_i,
  input  logic         z_avail_clr_i,
  input  logic         pushing_y_i,
  output sched_state_e state_o,
  output logic         stall_o,
  output logic         start_compute_o,
  output logic         reg_enable_o,
  output logic         accumulate_o,
  output logic         w_loaded_o,
  output logic         busy_o
);

  localparam int unsigned WaitW = $clog2(`MMS_PIPE_REGS + 1);

  sched_state_e     state_q, state_d;
  logic [WaitW-1:0] wait_q;
  logic             wait_end;
  logic             first_load_q, computing_q, reg_enable_q;
  logic             stall, preload_ok;

  // Weights, the next X tile and the next Y tile are checked only while loading W
  assign stall = (state_q == LOAD_W) && (
                   (!w_valid_i && !w_done_i) ||
                   (x_refill_due_i && x_shift_end_i && !flags_i.x_full) ||
                   (y_check_due_i && !flags_i.z_loaded));

  assign preload_ok = flags_i.x_full && (!cfg_i.y_needed || flags_i.z_loaded);
  assign wait_end   = wait_q == WaitW'(`MMS_PIPE_REGS);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = PRELOAD;
        end
      end
      PRELOAD: begin
        if (preload_ok) begin
          state_d = LOAD_W;
        end
      end
      LOAD_W: begin
        if (w_done_i && z_avail_clr_i) begin
          state_d = IDLE;
        end else if (!stall) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (wait_end) begin
          state_d = LOAD_W;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      reg_enable_q <= 1'b0;
    end else if (clear_i) begin
      state_q      <= IDLE;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      reg_enable_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      reg_enable_q <= computing_q && !stall;
      if (state_q == WAIT) begin
        wait_q <= wait_end ? '0 : wait_q + 1'b1;
      end
      // A new job re-arms the first load
      if (state_q == IDLE) begin
        first_load_q <= 1'b1;
      end else if (state_q == LOAD_W && !stall) begin
        first_load_q <= 1'b0;
      end
      if (state_q == PRELOAD && state_d == LOAD_W) begin
        computing_q <= 1'b1;
      end else if (state_d == IDLE) begin
        computing_q <= 1'b0;
      end
    end
  end

  assign state_o         = state_q;
  assign stall_o         = stall;
  assign start_compute_o = first_load_q && state_d == LOAD_W && !stall;
  assign reg_enable_o    = reg_enable_q;
  assign accumulate_o    = !pushing_y_i;
  assign w_loaded_o      = (state_q == LOAD_W) && !stall;
  assign busy_o          = state_q != IDLE;

endmodule

// File: hdl/mm_scheduler.sv
// ------------------------------
// Top of the matrix-multiply scheduler; pulse clear_i between jobs
// ------------------------------
module mm_scheduler
  import mm_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       start_i,
  input  iter_cfg_t  cfg_i,
  input  buf_flags_t flags_i,
  input  logic       x_valid_i,
  input  logic       w_valid_i,
  input  logic       y_valid_i,
  input  logic       z_ready_i,
  output x_ctrl_t    x_ctrl_o,
  output w_ctrl_t    w_ctrl_o,
  output z_ctrl_t    z_ctrl_o,
  output logic       reg_enable_o,
  output logic       accumulate_o,
  output logic       w_loaded_o,
  output logic       busy_o
);

  sched_state_e state;
  logic         stall, start_compute;
  logic         x_refill_due, x_shift_end;
  logic         w_done, w_col_wrap;
  logic         y_check_due, z_avail_clr, pushing_y;

  sched_fsm sched_fsm_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .start_i         (start_i),
    .cfg_i           (cfg_i),
    .flags_i         (flags_i),
    .w_valid_i       (w_valid_i),
    .x_refill_due_i  (x_refill_due),
    .x_shift_end_i   (x_shift_end),
    .w_done_i        (w_done),
    .y_check_due_i   (y_check_due),
    .z_avail_clr_i   (z_avail_clr),
    .pushing_y_i     (pushing_y),
    .state_o         (state),
    .stall_o         (stall),
    .start_compute_o (start_compute),
    .reg_enable_o    (reg_enable_o),
    .accumulate_o    (accumulate_o),
    .w_loaded_o      (w_loaded_o),
    .busy_o          (busy_o)
  );

  x_iter_ctrl x_iter_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .start_i        (start_i),
    .cfg_i          (cfg_i),
    .flags_i        (flags_i),
    .x_valid_i      (x_valid_i),
    .state_i        (state),
    .stall_i        (stall),
    .x_ctrl_o       (x_ctrl_o),
    .x_refill_due_o (x_refill_due),
    .x_shift_end_o  (x_shift_end)
  );

  w_iter_ctrl w_iter_ctrl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .cfg_i        (cfg_i),
    .w_valid_i    (w_valid_i),
    .state_i      (state),
    .stall_i      (stall),
    .w_ctrl_o     (w_ctrl_o),
    .w_done_o     (w_done),
    .w_col_wrap_o (w_col_wrap)
  );

  z_iter_ctrl z_iter_ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .cfg_i           (cfg_i),
    .flags_i         (flags_i),
    .y_valid_i       (y_valid_i),
    .z_ready_i       (z_ready_i),
    .stall_i         (stall),
    .start_compute_i (start_compute),
    .reg_enable_i    (reg_enable_o),
    .w_col_wrap_i    (w_col_wrap),
    .w_done_i        (w_done),
    .z_ctrl_o        (z_ctrl_o),
    .y_check_due_o   (y_check_due),
    .z_avail_clr_o   (z_avail_clr),
    .pushing_y_o     (pushing_y)
  );

endmodule

// File: dv/mm_scheduler_assertions.sv
// ------------------------------
// Concurrent checks bound into the scheduler top level
// ------------------------------
`include "mm_sched_cfg.svh"

module mm_scheduler_assertions
  import mm_sched_pkg::*;
(
  input logic    clk_i,
  input logic    rst_ni,
  input logic    clear_i,
  input logic    w_valid_i,
  input logic    stall_i,
  input w_ctrl_t w_ctrl_i,
  input logic    reg_enable_i,
  input logic    w_loaded_i,
  input logic    busy_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [3:0] since_load_q;

  // Cycles since the last accepted W row, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_load_q <= '1;
    end else if (w_loaded_i) begin
      since_load_q <= '0;
    end else if (since_load_q != '1) begin
      since_load_q <= since_load_q + 1'b1;
    end
  end

  // A weight row is only taken when the W stream offers one
  load_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_ctrl_i.load |-> w_valid_i)
    else $error("W load strobe while w_valid_i is low");

  // The engine registers stay frozen for the cycle after a stall
  no_enable_after_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |=> !reg_enable_i)
    else $error("reg_enable_o high in the cycle after a stall");

  clear_ends_job: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> !busy_i)
    else $error("busy_o still high after clear_i");

  // Every accepted W row is followed by the whole pipeline wait
  wait_after_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_loaded_i |-> since_load_q >= 4'(`MMS_PIPE_REGS + 1))
    else $error("w_loaded_o came back before the pipeline wait ended");

endmodule

bind mm_scheduler mm_scheduler_assertions mm_scheduler_assertions_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .clear_i      (clear_i),
  .w_valid_i    (w_valid_i),
  .stall_i      (stall),
  .w_ctrl_i     (w_ctrl_o),
  .reg_enable_i (reg_enable_o),
  .w_loaded_i   (w_loaded_o),
  .busy_i       (busy_o)
);

// File: dv/tb_mm_scheduler.sv
// ------------------------------
// Testbench of the scheduler, runs the jobs listed in the golden file
// Needs the include folder on the search path
// ------------------------------
`include "mm_sched_cfg.svh"

module tb_mm_scheduler
  import mm_sched_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxJobs = 32;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       clear;
  logic       start;
  iter_cfg_t  cfg;
  buf_flags_t flags = '0;
  logic       x_valid;
  logic       w_valid = 1'b0;
  logic       y_valid = 1'b0;
  logic       z_ready = 1'b1;
  x_ctrl_t    x_ctrl;
  w_ctrl_t    w_ctrl;
  z_ctrl_t    z_ctrl;
  logic       reg_enable, accumulate, w_loaded, busy;

  iter_cfg_t job_cfg   [MaxJobs];
  int        job_stall [MaxJobs];
  int        job_loads [MaxJobs];
  int        job_last  [MaxJobs];
  int        num_jobs;

  int load_cnt = 0;
  int last_cnt = 0;
  int shift_cnt = 0;
  int fill_cnt = 0;
  int stall_pct = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  mm_scheduler mm_scheduler_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .clear_i      (clear),
    .start_i      (start),
    .cfg_i        (cfg),
    .flags_i      (flags),
    .x_valid_i    (x_valid),
    .w_valid_i    (w_valid),
    .y_valid_i    (y_valid),
    .z_ready_i    (z_ready),
    .x_ctrl_o     (x_ctrl),
    .w_ctrl_o     (w_ctrl),
    .z_ctrl_o     (z_ctrl),
    .reg_enable_o (reg_enable),
    .accumulate_o (accumulate),
    .w_loaded_o   (w_loaded),
    .busy_o       (busy)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Width of the W tile at a given load, from the column that load belongs to
  function automatic logic [31:0] expected_width(input int idx);
    int col;
    col = (idx / int'(cfg.w_row_iters)) % int'(cfg.w_col_iters);
    if (col == int'(cfg.w_col_iters) - 1 && cfg.w_width_lo != '0) begin
      return 32'(cfg.w_width_lo);
    end else begin
      return 32'(`MMS_DEPTH);
    end
  endfunction

  task automatic check_idle_outputs();
    check_eq("x_ctrl.load", 32'(x_ctrl.load), 32'h0);
    check_eq("x_ctrl.h_shift", 32'(x_ctrl.h_shift), 32'h0);
    check_eq("x_ctrl.rst_w_index", 32'(x_ctrl.rst_w_index), 32'h0);
    check_eq("x_ctrl.pad_setup", 32'(x_ctrl.pad_setup), 32'h0);
    check_eq("x_ctrl.last_x", 32'(x_ctrl.last_x), 32'h0);
    check_eq("w_ctrl.load", 32'(w_ctrl.load), 32'h0);
    check_eq("w_ctrl.shift", 32'(w_ctrl.shift), 32'h0);
    check_eq("w_ctrl.zero_set", 32'(w_ctrl.zero_set), 32'h0);
    check_eq("z_ctrl.y_push_enable", 32'(z_ctrl.y_push_enable), 32'h0);
    check_eq("z_ctrl.fill", 32'(z_ctrl.fill), 32'h0);
    check_eq("reg_enable_o", 32'(reg_enable), 32'h0);
    check_eq("w_loaded_o", 32'(w_loaded), 32'h0);
    check_eq("busy_o", 32'(busy), 32'h0);
    // No Y tile is being pushed, so the engine accumulates
    check_eq("accumulate_o", 32'(accumulate), 32'h1);
  endtask

  task automatic read_golden();
    int    fd;
    int    n;
    int    v[12];
    string line;
    num_jobs = 0;
    fd = $fopen("dv/sched_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file dv/sched_golden.txt");
      $display("TB FAILED");
      $fatal(1);
    end else begin
      while (!$feof(fd) && num_jobs < MaxJobs) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
          if (n == 12) begin
            job_cfg[num_jobs].x_col_iters = 16'(v[0]);
            job_cfg[num_jobs].x_row_iters = 16'(v[1]);
            job_cfg[num_jobs].w_col_iters = 16'(v[2]);
            job_cfg[num_jobs].w_row_iters = 16'(v[3]);
            job_cfg[num_jobs].x_height_lo = 8'(v[4]);
            job_cfg[num_jobs].x_width_lo  = 8'(v[5]);
            job_cfg[num_jobs].w_height_lo = 8'(v[6]);
            job_cfg[num_jobs].w_width_lo  = 8'(v[7]);
            job_cfg[num_jobs].y_needed    = v[8][0];
            job_stall[num_jobs] = v[9];
            job_loads[num_jobs] = v[10];
            job_last[num_jobs]  = v[11];
            num_jobs++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Random gaps in the weight stream and random levels on the Y/Z handshake inputs
  always @(posedge clk) begin
    w_valid <= int'($urandom % 100) >= stall_pct;
    y_valid <= $urandom % 2 == 1;
    z_ready <= $urandom % 2 == 1;
  end

  // Buffer model and strobe counters
  always @(posedge clk) begin
    if (!rst_n || clear) begin
      flags     <= '0;
      shift_cnt <= 0;
      fill_cnt  <= 0;
      load_cnt  <= 0;
      last_cnt  <= 0;
    end else begin
      check_eq("z_ctrl.y_valid", 32'(z_ctrl.y_valid), 32'(y_valid));
      check_eq("z_ctrl.ready", 32'(z_ctrl.ready), 32'(z_ready));
      if (w_ctrl.load) begin
        check_eq("w_ctrl.width", 32'(w_ctrl.width), expected_width(load_cnt));
        load_cnt <= load_cnt + 1;
      end
      if (x_ctrl.last_x) begin
        last_cnt <= last_cnt + 1;
      end
      flags.x_empty <= 1'b0;
      // The X buffer reports full three cycles after the first load of a refill
      if (x_ctrl.load && fill_cnt == 0 && !flags.x_full) begin
        fill_cnt <= 1;
      end else if (fill_cnt == 3) begin
        flags.x_full <= 1'b1;
        fill_cnt     <= 0;
      end else if (fill_cnt != 0) begin
        fill_cnt <= fill_cnt + 1;
      end
      // A full shift pass drains the X tile
      if (x_ctrl.h_shift) begin
        if (shift_cnt == `MMS_ARRAY_H - 1) begin
          shift_cnt     <= 0;
          flags.x_empty <= 1'b1;
          flags.x_full  <= 1'b0;
          fill_cnt      <= 0;
        end else begin
          shift_cnt <= shift_cnt + 1;
        end
      end
      if (z_ctrl.y_push_enable) begin
        flags.z_loaded <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, a job did not finish", cycle_cnt);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  task automatic launch(input int idx, input int pct);
    @(posedge clk);
    cfg       <= job_cfg[idx];
    stall_pct <= pct;
    clear     <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
  endtask

  // Starts a job and clears it once a couple of weight rows are in
  task automatic abort_job();
    launch(0, 0);
    while (load_cnt < 2) begin
      @(negedge clk);
    end
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(negedge clk);
    check_idle_outputs();
  endtask

  task automatic run_job(input int idx);
    launch(idx, job_stall[idx]);
    check_eq("busy_o", 32'(busy), 32'h1);
    while (busy) begin
      @(negedge clk);
    end
    // The last X tile can drain after busy_o has fallen
    while (last_cnt < job_last[idx]) begin
      @(negedge clk);
    end
    check_eq("w_ctrl.load count", 32'(load_cnt), 32'(job_loads[idx]));
    check_eq("x_ctrl.last_x count", 32'(last_cnt), 32'(job_last[idx]));
    check_eq("busy_o", 32'(busy), 32'h0);
  endtask

  initial begin
    int limit;
    void'($urandom(32'h654f_580b));
    rst_n   = 1'b0;
    clear   = 1'b0;
    start   = 1'b0;
    cfg     = '0;
    x_valid = 1'b1;
    read_golden();
    if (num_jobs == 0) begin
      $display("The golden file holds no jobs");
      $display("TB FAILED");
      $fatal(1);
    end else begin
      limit = 1000;
      for (int i = 0; i < num_jobs; i++) begin
        limit += job_loads[i] * (`MMS_PIPE_REGS + 2) * 4;
      end
      cycle_limit = limit;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_idle_outputs();
      abort_job();
      for (int i = 0; i < num_jobs; i++) begin
        run_job(i);
      end
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: vlog.f
+incdir+include
hdl/mm_sched_pkg.sv
hdl/x_iter_ctrl.sv
hdl/w_iter_ctrl.sv
hdl/z_iter_ctrl.sv
hdl/sched_fsm.sv
hdl/mm_scheduler.sv
dv/mm_scheduler_assertions.sv
dv/tb_mm_scheduler.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_mm_scheduler
FILELIST  = vlog.f
OBJDIR    = obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: dv/sched_golden.txt
# x_col x_row w_col w_row x_h_lo x_w_lo w_h_lo w_w_lo y_needed stall_pct loads last_x
# Counts and leftovers are decimal, stall_pct is the chance in percent that w_valid is low
1 1 1 4 0 0 0 5 0 0 4 1
1 2 1 4 3 2 0 9 0 30 8 1
1 3 1 4 0 0 2 5 0 50 12 1
2 1 1 8 6 0 0 1 0 20 8 1
1 2 1 3 0 3 1 5 0 10 6 1
